// File: design/tcls_pkg.sv
// Shared types, register map and timing constants, imported by every lockstep RTL block
package tcls_pkg;

    // Number of redundant cores behind the voter
    localparam int unsigned NUM_CORES = 3;

    //**************************************************************************
    // Data bus
    //**************************************************************************
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;

    // req + we + addr + wdata + be, flattened for the vote
    localparam int unsigned DATA_REQ_W = 2 + $bits(addr_t) + $bits(data_t) + $bits(be_t);

    typedef logic [NUM_CORES-1:0] core_vec_t;
    typedef logic [1:0]           core_idx_t;

    // Interrupts and events
    typedef logic [4:0]  irq_id_t;
    typedef logic [31:0] irq_lines_t;
    typedef logic [31:0] event_vec_t;

    localparam int unsigned MISMATCH_EVENT_IDX = 25;

    //**************************************************************************
    // Recovery
    //**************************************************************************
    localparam int unsigned RECOVER_CYCLES = 4;
    localparam int unsigned RECOVER_CNT_W  = $clog2(RECOVER_CYCLES + 1);

    typedef logic [RECOVER_CNT_W-1:0] recover_cnt_t;
    typedef logic [15:0]              cnt_t;

    typedef enum logic {
        TCLS_RUN,
        TCLS_RECOVER
    } tcls_state_e;

    // Register offsets inside the 4 KB APB window
    localparam int unsigned REG_OFFSET_W = 12;

    typedef enum logic [REG_OFFSET_W-1:0] {
        REG_CTRL         = 12'h000,
        REG_STATUS       = 12'h004,
        REG_MISMATCH_CNT = 12'h008
    } tcls_reg_e;

endpackage

// File: design/tcls_voter.sv
// Majority voter for the three core data requests, drives the single L2 request port
`timescale 1ns/1ps

module tcls_voter (
    input  tcls_pkg::core_vec_t                       core_req_i,
    input  tcls_pkg::core_vec_t                       core_we_i,
    input  tcls_pkg::addr_t [tcls_pkg::NUM_CORES-1:0] core_addr_i,
    input  tcls_pkg::data_t [tcls_pkg::NUM_CORES-1:0] core_wdata_i,
    input  tcls_pkg::be_t   [tcls_pkg::NUM_CORES-1:0] core_be_i,
    input  logic                                      recover_i,

    output logic                                      l2_req_o,
    output logic                                      l2_we_o,
    output tcls_pkg::addr_t                           l2_addr_o,
    output tcls_pkg::data_t                           l2_wdata_o,
    output tcls_pkg::be_t                             l2_be_o,
    output tcls_pkg::core_vec_t                       disagree_o
);

    import tcls_pkg::*;

    // One flat request word per core
    logic [NUM_CORES-1:0][DATA_REQ_W-1:0] core_bits;
    logic [DATA_REQ_W-1:0]                voted_bits;
    logic                                 voted_req;

    //**************************************************************************
    // Flatten the request fields
    //**************************************************************************
    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            core_bits[i] = {core_req_i[i],
                            core_we_i[i],
                            core_addr_i[i],
                            core_wdata_i[i],
                            core_be_i[i]};
        end
    end

    // Two out of three, bit by bit
    assign voted_bits = (core_bits[0] & core_bits[1]) |
                        (core_bits[0] & core_bits[2]) |
                        (core_bits[1] & core_bits[2]);

    assign {voted_req, l2_we_o, l2_addr_o, l2_wdata_o, l2_be_o} = voted_bits;

    // Cores are held in reset, nothing may reach L2
    assign l2_req_o = voted_req & ~recover_i;

    //**************************************************************************
    // Disagreement flags
    //**************************************************************************
    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            // any differing bit in any field marks the core
            disagree_o[i] = |(core_bits[i] ^ voted_bits);
        end
    end

endmodule

// File: design/tcls_recovery_ctrl.sv
// Lockstep FSM: classifies mismatches, resets the cores for a fixed window and keeps status
`timescale 1ns/1ps

module tcls_recovery_ctrl (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  tcls_pkg::core_vec_t disagree_i,
    input  logic                recover_en_i,
    input  logic                cnt_clear_i,

    output tcls_pkg::core_vec_t core_rst_n_o,
    output logic                recover_o,
    output logic                mismatch_evt_o,
    output tcls_pkg::cnt_t      mismatch_cnt_o,
    output tcls_pkg::core_idx_t faulty_core_o,
    output logic                fatal_o
);

    import tcls_pkg::*;

    tcls_state_e  state_q, state_d;
    recover_cnt_t recover_cnt_q, recover_cnt_d;

    logic         single_mm;
    logic         multi_mm;
    core_idx_t    mm_idx;

    logic         evt_q;
    cnt_t         cnt_q;
    core_idx_t    faulty_q;
    logic         fatal_q;

    //**************************************************************************
    // Mismatch classification, only while running
    //**************************************************************************
    assign single_mm = (state_q == TCLS_RUN) && $onehot(disagree_i);
    assign multi_mm  = (state_q == TCLS_RUN) && (disagree_i != '0) && !$onehot(disagree_i);

    // Index of the odd core out
    always_comb begin
        mm_idx = '0;
        for (int i = 0; i < NUM_CORES; i++) begin
            if (disagree_i[i]) begin
                mm_idx = core_idx_t'(i);
            end
        end
    end

    //**************************************************************************
    // Next state
    //**************************************************************************
    always_comb begin
        state_d       = state_q;
        recover_cnt_d = recover_cnt_q;
        case (state_q)
            TCLS_RUN: begin
                if (single_mm && recover_en_i) begin
                    state_d       = TCLS_RECOVER;
                    recover_cnt_d = recover_cnt_t'(RECOVER_CYCLES - 1);
                end
            end
            TCLS_RECOVER: begin
                if (recover_cnt_q == '0) begin
                    state_d = TCLS_RUN;
                end else begin
                    recover_cnt_d = recover_cnt_q - 1'b1;
                end
            end
            default: state_d = TCLS_RUN;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= TCLS_RUN;
            recover_cnt_q <= '0;
            evt_q         <= 1'b0;
            cnt_q         <= '0;
            faulty_q      <= '0;
            fatal_q       <= 1'b0;
        end else begin
            state_q       <= state_d;
            recover_cnt_q <= recover_cnt_d;
            evt_q         <= single_mm;
            // Clear wins over a coincident mismatch, counter saturates
            if (cnt_clear_i) begin
                cnt_q <= '0;
            end else if (single_mm && (cnt_q != '1)) begin
                cnt_q <= cnt_q + 1'b1;
            end
            if (single_mm) begin
                faulty_q <= mm_idx;
            end
            if (multi_mm) begin
                fatal_q <= 1'b1;
            end
        end
    end

    assign recover_o      = (state_q == TCLS_RECOVER);
    assign core_rst_n_o   = {NUM_CORES{~recover_o}};
    assign mismatch_evt_o = evt_q;
    assign mismatch_cnt_o = cnt_q;
    assign faulty_core_o  = faulty_q;
    assign fatal_o        = fatal_q;

endmodule

// File: design/tcls_apb_regs.sv
// APB register slave holding the lockstep control bit and reporting status and mismatch count
`timescale 1ns/1ps

module tcls_apb_regs (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  tcls_pkg::addr_t     paddr_i,
    input  tcls_pkg::data_t     pwdata_i,
    output tcls_pkg::data_t     prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,

    input  tcls_pkg::cnt_t      mismatch_cnt_i,
    input  tcls_pkg::core_idx_t faulty_core_i,
    input  logic                fatal_i,

    output logic                recover_en_o,
    output logic                cnt_clear_o
);

    import tcls_pkg::*;

    tcls_reg_e reg_offset;
    logic      access;
    logic      wr_access;
    logic      offset_valid;
    data_t     rdata;
    logic      recover_en_q;

    assign reg_offset = tcls_reg_e'(paddr_i[REG_OFFSET_W-1:0]);
    assign access     = psel_i & penable_i;
    assign wr_access  = access & pwrite_i;

    //**************************************************************************
    // Read mux and offset decode
    //**************************************************************************
    always_comb begin
        rdata        = '0;
        offset_valid = 1'b1;
        case (reg_offset)
            REG_CTRL: begin
                rdata[0] = recover_en_q;
            end
            REG_STATUS: begin
                // Last faulty core in [1:0], fatal flag in [2]
                rdata[1:0] = faulty_core_i;
                rdata[2]   = fatal_i;
            end
            REG_MISMATCH_CNT: begin
                rdata = data_t'(mismatch_cnt_i);
            end
            default: begin
                offset_valid = 1'b0;
            end
        endcase
    end

    //**************************************************************************
    // Control register
    //**************************************************************************
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Recovery is on out of reset
            recover_en_q <= 1'b1;
        end else if (wr_access && (reg_offset == REG_CTRL)) begin
            recover_en_q <= pwdata_i[0];
        end
    end

    // No wait states
    assign pready_o  = access;
    assign pslverr_o = access & ~offset_valid;
    assign prdata_o  = access ? rdata : '0;

    assign recover_en_o = recover_en_q;

    // Any write to the counter offset clears it at the end of the access
    assign cnt_clear_o = wr_access & (reg_offset == REG_MISMATCH_CNT);

endmodule

// File: design/tcls_irq_fanout.sv
// Interrupt fan-out: id to one-hot lines for the cores, majority vote of their acknowledges
`timescale 1ns/1ps

module tcls_irq_fanout (
    input  logic                                        irq_req_i,
    input  tcls_pkg::irq_id_t                           irq_id_i,
    input  tcls_pkg::core_vec_t                         core_irq_ack_i,
    input  tcls_pkg::irq_id_t [tcls_pkg::NUM_CORES-1:0] core_irq_ack_id_i,

    output tcls_pkg::irq_lines_t                        irq_lines_o,
    output logic                                        irq_ack_o,
    output tcls_pkg::irq_id_t                           irq_ack_id_o
);

    import tcls_pkg::*;

    // Back to one line per interrupt
    always_comb begin
        irq_lines_o = '0;
        if (irq_req_i) begin
            irq_lines_o[irq_id_i] = 1'b1;
        end
    end

    //**************************************************************************
    // Acknowledge vote
    //**************************************************************************
    assign irq_ack_o = (core_irq_ack_i[0] & core_irq_ack_i[1]) |
                       (core_irq_ack_i[0] & core_irq_ack_i[2]) |
                       (core_irq_ack_i[1] & core_irq_ack_i[2]);

    // Same vote on the ack id, bit by bit
    assign irq_ack_id_o = (core_irq_ack_id_i[0] & core_irq_ack_id_i[1]) |
                          (core_irq_ack_id_i[0] & core_irq_ack_id_i[2]) |
                          (core_irq_ack_id_i[1] & core_irq_ack_id_i[2]);

endmodule

// File: design/fc_tcls_top.sv
// Top of the triple-core lockstep block, placed between three core copies and one L2 data port
`timescale 1ns/1ps

module fc_tcls_top (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,

    // Core side
    input  tcls_pkg::core_vec_t                          core_data_req_i,
    input  tcls_pkg::addr_t  [tcls_pkg::NUM_CORES-1:0]   core_data_addr_i,
    input  tcls_pkg::core_vec_t                          core_data_we_i,
    input  tcls_pkg::data_t  [tcls_pkg::NUM_CORES-1:0]   core_data_wdata_i,
    input  tcls_pkg::be_t    [tcls_pkg::NUM_CORES-1:0]   core_data_be_i,
    output tcls_pkg::core_vec_t                          core_rst_n_o,

    // L2 side
    output logic                                         l2_data_req_o,
    output tcls_pkg::addr_t                              l2_data_addr_o,
    output logic                                         l2_data_we_o,
    output tcls_pkg::data_t                              l2_data_wdata_o,
    output tcls_pkg::be_t                                l2_data_be_o,

    // Interrupts
    input  logic                                         irq_req_i,
    input  tcls_pkg::irq_id_t                            irq_id_i,
    output tcls_pkg::irq_lines_t                         irq_lines_o,
    input  tcls_pkg::core_vec_t                          core_irq_ack_i,
    input  tcls_pkg::irq_id_t [tcls_pkg::NUM_CORES-1:0]  core_irq_ack_id_i,
    output logic                                         irq_ack_o,
    output tcls_pkg::irq_id_t                            irq_ack_id_o,

    // Events
    input  tcls_pkg::event_vec_t                         events_i,
    output tcls_pkg::event_vec_t                         events_o,

    // APB
    input  logic                                         psel_i,
    input  logic                                         penable_i,
    input  logic                                         pwrite_i,
    input  tcls_pkg::addr_t                              paddr_i,
    input  tcls_pkg::data_t                              pwdata_i,
    output tcls_pkg::data_t                              prdata_o,
    output logic                                         pready_o,
    output logic                                         pslverr_o
);

    import tcls_pkg::*;

    core_vec_t disagree;
    logic      recover;
    logic      recover_en;
    logic      cnt_clear;
    logic      mismatch_evt;
    cnt_t      mismatch_cnt;
    core_idx_t faulty_core;
    logic      fatal;

    //**************************************************************************
    // Data request vote
    //**************************************************************************
    tcls_voter u_voter (
        .core_req_i   (core_data_req_i),
        .core_we_i    (core_data_we_i),
        .core_addr_i  (core_data_addr_i),
        .core_wdata_i (core_data_wdata_i),
        .core_be_i    (core_data_be_i),
        .recover_i    (recover),
        .l2_req_o     (l2_data_req_o),
        .l2_we_o      (l2_data_we_o),
        .l2_addr_o    (l2_data_addr_o),
        .l2_wdata_o   (l2_data_wdata_o),
        .l2_be_o      (l2_data_be_o),
        .disagree_o   (disagree)
    );

    tcls_recovery_ctrl u_recovery_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .disagree_i     (disagree),
        .recover_en_i   (recover_en),
        .cnt_clear_i    (cnt_clear),
        .core_rst_n_o   (core_rst_n_o),
        .recover_o      (recover),
        .mismatch_evt_o (mismatch_evt),
        .mismatch_cnt_o (mismatch_cnt),
        .faulty_core_o  (faulty_core),
        .fatal_o        (fatal)
    );

    //**************************************************************************
    // Register slave and interrupts
    //**************************************************************************
    tcls_apb_regs u_apb_regs (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .mismatch_cnt_i (mismatch_cnt),
        .faulty_core_i  (faulty_core),
        .fatal_i        (fatal),
        .recover_en_o   (recover_en),
        .cnt_clear_o    (cnt_clear)
    );

    tcls_irq_fanout u_irq_fanout (
        .irq_req_i         (irq_req_i),
        .irq_id_i          (irq_id_i),
        .core_irq_ack_i    (core_irq_ack_i),
        .core_irq_ack_id_i (core_irq_ack_id_i),
        .irq_lines_o       (irq_lines_o),
        .irq_ack_o         (irq_ack_o),
        .irq_ack_id_o      (irq_ack_id_o)
    );

    // Mismatch pulse takes over its event line, the rest passes through
    always_comb begin
        events_o                     = events_i;
        events_o[MISMATCH_EVENT_IDX] = mismatch_evt;
    end

endmodule

// File: verif/tb_fc_tcls_top.sv
// Self-checking testbench that replays the case file against the lockstep top
`timescale 1ns/1ps

module tb_fc_tcls_top;

    import tcls_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int WAIT_CYCLES = 16;
    localparam int MAX_CASES   = 64;

    logic                    clk_i;
    logic                    rst_n_i;

    core_vec_t               core_req;
    core_vec_t               core_we;
    addr_t [NUM_CORES-1:0]   core_addr;
    data_t [NUM_CORES-1:0]   core_wdata;
    be_t   [NUM_CORES-1:0]   core_be;
    core_vec_t               core_rst_n;

    logic                    l2_req;
    addr_t                   l2_addr;
    logic                    l2_we;
    data_t                   l2_wdata;
    be_t                     l2_be;

    logic                    irq_req;
    irq_id_t                 irq_id;
    irq_lines_t              irq_lines;
    core_vec_t               core_ack;
    irq_id_t [NUM_CORES-1:0] core_ack_id;
    logic                    irq_ack;
    irq_id_t                 irq_ack_id;

    event_vec_t              events_in;
    event_vec_t              events_out;

    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    addr_t                   paddr;
    data_t                   pwdata;
    data_t                   prdata;
    logic                    pready;
    logic                    pslverr;

    int seed = 32'h81649954;
    int errors;
    int passed_tests;
    int failed_tests;

    fc_tcls_top u_dut (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .core_data_req_i   (core_req),
        .core_data_addr_i  (core_addr),
        .core_data_we_i    (core_we),
        .core_data_wdata_i (core_wdata),
        .core_data_be_i    (core_be),
        .core_rst_n_o      (core_rst_n),
        .l2_data_req_o     (l2_req),
        .l2_data_addr_o    (l2_addr),
        .l2_data_we_o      (l2_we),
        .l2_data_wdata_o   (l2_wdata),
        .l2_data_be_o      (l2_be),
        .irq_req_i         (irq_req),
        .irq_id_i          (irq_id),
        .irq_lines_o       (irq_lines),
        .core_irq_ack_i    (core_ack),
        .core_irq_ack_id_i (core_ack_id),
        .irq_ack_o         (irq_ack),
        .irq_ack_id_o      (irq_ack_id),
        .events_i          (events_in),
        .events_o          (events_out),
        .psel_i            (psel),
        .penable_i         (penable),
        .pwrite_i          (pwrite),
        .paddr_i           (paddr),
        .pwdata_i          (pwdata),
        .prdata_o          (prdata),
        .pready_o          (pready),
        .pslverr_o         (pslverr)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    //**************************************************************************
    // Compare tasks
    //**************************************************************************
    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_be(input be_t got, input be_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flags(input core_vec_t got, input core_vec_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_irq(input irq_lines_t got, input irq_lines_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_irq_id(input irq_id_t got, input irq_id_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_events(input event_vec_t got, input event_vec_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    //**************************************************************************
    // Drivers
    //**************************************************************************
    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic drive_agreed(input core_vec_t req, input addr_t addr, input data_t wdata);
        core_req   = req;
        core_we    = '0;
        core_addr  = {NUM_CORES{addr}};
        core_wdata = {NUM_CORES{wdata}};
        core_be    = {NUM_CORES{4'hf}};
    endtask

    task automatic apb_transfer(input logic write, input addr_t addr, input data_t wdata,
                                output data_t rdata, output logic err);
        int guard;
        next_cycle();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        next_cycle();
        penable = 1'b1;
        #1;
        check_bit(pready, 1'b1, "pready in access cycle");
        guard = 0;
        while (!pready && guard < WAIT_CYCLES) begin
            next_cycle();
            #1;
            guard++;
        end
        if (!pready) begin
            $display("APB slave never raised pready for address %h", addr);
            errors++;
        end
        rdata = prdata;
        err   = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input addr_t offset, input data_t exp, input logic exp_err);
        data_t rdata;
        logic  err;
        apb_transfer(1'b0, offset, '0, rdata, err);
        check_data(rdata, exp, "APB read data");
        check_bit(err, exp_err, "APB pslverr on read");
    endtask

    task automatic write_reg(input addr_t offset, input data_t wdata, input logic exp_err);
        data_t rdata;
        logic  err;
        apb_transfer(1'b1, offset, wdata, rdata, err);
        check_bit(err, exp_err, "APB pslverr on write");
    endtask

    //**************************************************************************
    // Case runners
    //**************************************************************************
    // One core is corrupted for one cycle and the pulse, reset window and registers follow
    task automatic run_fault(input core_idx_t bad, input data_t mask, input int exp_rst,
                             input data_t exp_status, input data_t exp_cnt);
        addr_t      addr;
        data_t      wdata;
        event_vec_t pulse;
        int         n;
        addr  = $random(seed);
        wdata = $random(seed);
        pulse = '0;
        pulse[MISMATCH_EVENT_IDX] = 1'b1;
        next_cycle();
        events_in = '0;
        drive_agreed(3'b111, addr, wdata);
        core_addr[bad]  = addr ^ mask;
        core_wdata[bad] = wdata ^ mask;
        core_we[bad]    = 1'b1;
        core_be[bad]    = 4'h0;
        #1;
        check_addr(l2_addr, addr, "voted address");
        check_data(l2_wdata, wdata, "voted wdata");
        check_bit(l2_we, 1'b0, "voted write enable");
        check_be(l2_be, 4'hf, "voted byte enables");
        check_bit(l2_req, 1'b1, "L2 request before recovery");
        next_cycle();
        drive_agreed(3'b111, addr, wdata);
        #1;
        check_events(events_out, pulse, "events with mismatch pulse");
        n = 0;
        while (core_rst_n != 3'b111 && n < WAIT_CYCLES) begin
            check_flags(core_rst_n, 3'b000, "core resets in recovery");
            check_bit(l2_req, 1'b0, "L2 request in recovery");
            next_cycle();
            #1;
            check_events(events_out, '0, "events after the pulse");
            n++;
        end
        if (core_rst_n != 3'b111) begin
            $display("Core resets were not released within %0d cycles", WAIT_CYCLES);
            errors++;
        end
        check_data(data_t'(n), data_t'(exp_rst), "cycles with cores in reset");
        next_cycle();
        drive_agreed(3'b000, addr, wdata);
        #1;
        check_events(events_out, '0, "events after the mismatch");
        read_reg(addr_t'(REG_STATUS), exp_status, 1'b0);
        read_reg(addr_t'(REG_MISMATCH_CNT), exp_cnt, 1'b0);
    endtask

    // Every pair of cores differs so two cores disagree with the vote
    task automatic run_triple(input addr_t mask, input data_t exp_status, input data_t exp_cnt);
        addr_t addr;
        data_t wdata;
        addr  = $random(seed);
        wdata = $random(seed);
        next_cycle();
        events_in = '0;
        drive_agreed(3'b111, addr, wdata);
        core_addr[1] = addr ^ mask;
        core_addr[2] = addr ^ (mask << 1);
        #1;
        check_addr(l2_addr, addr, "voted address with three different cores");
        next_cycle();
        drive_agreed(3'b000, addr, wdata);
        #1;
        check_events(events_out, '0, "events after triple mismatch");
        check_flags(core_rst_n, 3'b111, "core resets after triple mismatch");
        read_reg(addr_t'(REG_STATUS), exp_status, 1'b0);
        read_reg(addr_t'(REG_MISMATCH_CNT), exp_cnt, 1'b0);
    endtask

    task automatic run_irq(input logic req, input irq_id_t id, input irq_lines_t exp_lines,
                           input core_vec_t ack, input logic [14:0] ack_ids,
                           input logic [5:0] exp_pair);
        next_cycle();
        irq_req     = req;
        irq_id      = id;
        core_ack    = ack;
        core_ack_id = ack_ids;
        #1;
        check_irq(irq_lines, exp_lines, "interrupt lines");
        check_bit(irq_ack, exp_pair[5], "voted acknowledge");
        check_irq_id(irq_ack_id, exp_pair[4:0], "voted acknowledge id");
    endtask

    task automatic run_events(input event_vec_t ev_in, input event_vec_t exp);
        next_cycle();
        events_in = ev_in;
        #1;
        check_events(events_out, exp, "event pass-through");
    endtask

    //**************************************************************************
    // Main sequence
    //**************************************************************************
    initial begin : main
        int           fd;
        int           code;
        int           n_case;
        int           errs_before;
        logic [63:0]  kind;
        logic [31:0]  arg [0:5];
        logic [1023:0] rest;
        errors       = 0;
        passed_tests = 0;
        failed_tests = 0;
        rst_n_i      = 1'b0;
        drive_agreed(3'b000, '0, '0);
        irq_req     = 1'b0;
        irq_id      = '0;
        core_ack    = '0;
        core_ack_id = '0;
        events_in   = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        repeat (2) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        fd = $fopen("verif/tcls_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file verif/tcls_cases.txt");
            errors++;
        end else begin
            n_case = 0;
            code   = $fscanf(fd, "%s", kind);
            while (code == 1 && n_case < MAX_CASES) begin
                if (kind == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h %h",
                                   arg[0], arg[1], arg[2], arg[3], arg[4], arg[5]);
                    errs_before = errors;
                    n_case++;
                    if (kind == "fault") begin
                        run_fault(arg[0][1:0], arg[1], arg[2], arg[3], arg[4]);
                    end else if (kind == "triple") begin
                        run_triple(arg[1], arg[3], arg[4]);
                    end else if (kind == "wr") begin
                        write_reg(arg[0], arg[1], arg[5][0]);
                    end else if (kind == "rd") begin
                        read_reg(arg[0], arg[2], arg[5][0]);
                    end else if (kind == "irq") begin
                        run_irq(arg[0][0], arg[1][4:0], arg[2], arg[3][2:0],
                                arg[4][14:0], arg[5][5:0]);
                    end else if (kind == "evt") begin
                        run_events(arg[0], arg[2]);
                    end else begin
                        $display("Unknown case kind in line %0d of the case file", n_case);
                        errors++;
                    end
                    if (errors == errs_before) begin
                        $display("test %0d (%0s) passed", n_case, kind);
                        passed_tests++;
                    end else begin
                        $display("test %0d (%0s) failed with %0d errors", n_case, kind,
                                 errors - errs_before);
                        failed_tests++;
                    end
                end
                code = $fscanf(fd, "%s", kind);
            end
            $fclose(fd);
        end

        $display("%0d tests passed, %0d tests failed", passed_tests, failed_tests);
        if (errors == 0 && passed_tests > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
design/tcls_pkg.sv
design/tcls_voter.sv
design/tcls_recovery_ctrl.sv
design/tcls_apb_regs.sv
design/tcls_irq_fanout.sv
design/fc_tcls_top.sv
verif/tb_fc_tcls_top.sv

// File: verif/tcls_cases.txt
# kind  a0  a1  a2  a3  a4  a5, all hex
# fault: core xor_mask reset_cycles exp_status exp_count -
# triple: - xor_mask - exp_status exp_count -
# wr / rd: offset wdata exp_rdata - - exp_pslverr
# irq: req id exp_lines ack_vec ack_ids{c2,c1,c0} exp_{ack,ack_id}
# evt: events_in - exp_events - - -
rd     0        0        1        0 0    0
rd     8        0        0        0 0    0
fault  1        00f0000f 4        1 1    0
fault  2        80000000 4        2 2    0
fault  0        00000100 4        0 3    0
wr     0        0        0        0 0    0
rd     0        0        0        0 0    0
fault  2        0000ff00 0        2 4    0
triple 0        00000011 0        6 4    0
wr     8        0        0        0 0    0
rd     8        0        0        0 0    0
wr     0        1        0        0 0    0
rd     0        0        1        0 0    0
rd     4        0        6        0 0    0
rd     10       0        0        0 0    1
wr     3c       1234     0        0 0    1
rd     0        0        1        0 0    0
irq    1        7        00000080 3 24e7 27
irq    0        7        00000000 4 0d83 03
irq    1        1f       80000000 7 7fff 3f
evt    ffffffff 0        fdffffff 0 0    0
evt    02000000 0        00000000 0 0    0
evt    12345678 0        10345678 0 0    0
fault  1        00000003 4        5 1    0
